/* board_specific_top.f */
logic/board_pkg.sv
logic/display_pkg.sv
logic/count_ctrl_if.sv
logic/tick_gen.sv
logic/key_frontend.sv
logic/bcd_digit.sv
logic/digit_scan.sv
logic/board_specific_top.sv
testbench/tb_board_specific_top.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --timescale 1ns/100ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps -Wall
TOP       = tb_board_specific_top
FLIST     = board_specific_top.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

/* testbench/tb_board_specific_top.sv */
module tb_board_specific_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int tick_period     = 20;
    localparam int debounce_cycles = 4;
    localparam int scan_period     = 2;
    localparam int count_mod       = 10 ** display_pkg::n_digits;
    localparam bit [31:0] seed     = 32'hd349_aef4;

    // Tick budget of all tests together with the overflow walk dominating
    localparam int test_ticks  = 4 + 12 + 12 + (count_mod + 16) + 12 + 4;
    localparam longint watchdog_ns = longint'(test_ticks + 200) * tick_period * 8;

    logic                                 clk;
    logic                                 rst_n;
    logic [board_pkg::w_key - 1:0]        key;
    logic [board_pkg::w_led - 1:0]        led;
    logic [7:0]                           abcdefgh;
    logic [display_pkg::n_digits - 1:0]   digit;

    // Reference model state
    int  exp_count     = 0;
    bit  exp_run       = 1'b0;
    bit  exp_down      = 1'b0;
    bit  exp_ovf       = 1'b0;
    bit  settling      = 1'b0;  // Key press in flight so state checks pause
    int  tick_count    = 0;
    logic tick_led_prev = 1'b0;
    logic [display_pkg::n_digits - 1:0] visited = '0;

    int error_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    board_specific_top #(
        .tick_period     ( tick_period     ),
        .debounce_cycles ( debounce_cycles ),
        .scan_period     ( scan_period     )
    )
    board_specific_top_inst
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //------------------------------------------------------------
    // Reference functions
    //------------------------------------------------------------

    function automatic int next_count(input int cnt, input bit down);
        if (down)
            return (cnt + count_mod - 1) % count_mod;
        return (cnt + 1) % count_mod;
    endfunction

    function automatic bit count_wraps(input int cnt, input bit down);
        return down ? (cnt == 0) : (cnt == count_mod - 1);
    endfunction

    function automatic int digit_value(input int cnt, input int idx);
        int v;
        v = cnt;
        repeat (idx) v = v / 10;
        return v % 10;
    endfunction

    // Segments a to h from the MSB down and flipped for the board pins
    function automatic logic [7:0] seg_byte(input int v);
        logic [7:0] pattern;
        logic [7:0] flipped;
        case (v)
            0:       pattern = 8'b1111_1100;
            1:       pattern = 8'b0110_0000;
            2:       pattern = 8'b1101_1010;
            3:       pattern = 8'b1111_0010;
            4:       pattern = 8'b0110_0110;
            5:       pattern = 8'b1011_0110;
            6:       pattern = 8'b1011_1110;
            7:       pattern = 8'b1110_0000;
            8:       pattern = 8'b1111_1110;
            9:       pattern = 8'b1111_0110;
            default: pattern = 8'b0000_0000;
        endcase
        for (int b = 0; b < 8; b++)
            flipped[b] = pattern[7 - b];
        return flipped;
    endfunction

    //------------------------------------------------------------
    // Reporting
    //------------------------------------------------------------

    task automatic value_error(input string sig, input int expected, input int actual);
        $display("error at %0d ns: %s expected %0h got %0h", $time, sig, expected, actual);
        error_count++;
    endtask

    task automatic check_failed(input string msg);
        $display("failure at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, error_count - errors_at_start);
        end
    endtask

    //------------------------------------------------------------
    // Compare process sampling on the falling edge
    //------------------------------------------------------------

    always @(negedge clk)
    begin
        int idx;
        bit changed;
        if (rst_n)
        begin
            changed = 1'b0;
            idx     = 0;
            if (led[board_pkg::led_tick] !== tick_led_prev)
            begin
                tick_led_prev = led[board_pkg::led_tick];
                tick_count++;
                if (!settling && !exp_run)
                    check_failed("led_tick toggled while the counter is stopped");
                if (count_wraps(exp_count, exp_down))
                    exp_ovf = 1'b1;
                exp_count = next_count(exp_count, exp_down);
                changed   = 1'b1;  // Segment register lags one cycle
            end

            if (!settling)
            begin
                if (led[board_pkg::led_run] !== exp_run)
                    value_error("led_run", int'(exp_run), int'(led[board_pkg::led_run]));
                if (led[board_pkg::led_down] !== exp_down)
                    value_error("led_down", int'(exp_down), int'(led[board_pkg::led_down]));
                if (led[board_pkg::led_ovf] !== exp_ovf)
                    value_error("led_ovf", int'(exp_ovf), int'(led[board_pkg::led_ovf]));
            end

            if (!$onehot(digit))
                check_failed($sformatf("digit select %b is not one-hot", digit));
            else
            begin
                visited |= digit;
                for (int d = 0; d < display_pkg::n_digits; d++)
                    if (digit[d])
                        idx = d;
                if (!changed && !settling
                    && abcdefgh !== seg_byte(digit_value(exp_count, idx)))
                    value_error($sformatf("abcdefgh[digit %0d]", idx),
                                int'(seg_byte(digit_value(exp_count, idx))), int'(abcdefgh));
            end
        end
    end

    //------------------------------------------------------------
    // Stimulus tasks
    //------------------------------------------------------------

    task automatic press_key(input int k);
        int hold;
        hold = debounce_cycles + 6 + int'($urandom % 6);
        @(posedge clk);
        settling = 1'b1;
        @(negedge clk);
        key[k] = 1'b0;  // Active low
        repeat (hold) @(negedge clk);
        key[k] = 1'b1;
        repeat (debounce_cycles + 10) @(posedge clk);
        case (k)
            board_pkg::key_run: exp_run  = ~exp_run;
            board_pkg::key_dir: exp_down = ~exp_down;
            default:
            begin
                exp_count = 0;
                exp_ovf   = 1'b0;
            end
        endcase
        settling = 1'b0;
    endtask

    // Too short to pass the debounce filter
    task automatic short_pulse(input int k);
        int len;
        len = 1 + int'($urandom % (debounce_cycles - 1));
        @(negedge clk);
        key[k] = 1'b0;
        repeat (len) @(negedge clk);
        key[k] = 1'b1;
        repeat (debounce_cycles + 6) @(posedge clk);
    endtask

    task automatic wait_ticks(input int n);
        int start;
        int cycles;
        start  = tick_count;
        cycles = 0;
        while (tick_count - start < n && cycles < (n + 4) * tick_period)
        begin
            @(posedge clk);
            cycles++;
        end
        if (tick_count - start < n)
            check_failed($sformatf("only %0d of %0d led_tick toggles arrived",
                                   tick_count - start, n));
    endtask

    task automatic wait_count(input int target, input int max_ticks);
        int cycles;
        cycles = 0;
        while (exp_count != target && cycles < max_ticks * tick_period)
        begin
            @(posedge clk);
            cycles++;
        end
        if (exp_count != target)
            check_failed($sformatf("count never reached %0d", target));
    endtask

    task automatic check_led(input string name, input int idx, input bit expected);
        @(negedge clk);
        if (led[idx] !== expected)
            value_error(name, int'(expected), int'(led[idx]));
    endtask

    task automatic check_full_scan();
        @(posedge clk);
        visited = '0;
        repeat (2 * display_pkg::n_digits * scan_period + 2) @(posedge clk);
        if (visited !== '1)
            value_error("digit visited", (1 << display_pkg::n_digits) - 1, int'(visited));
    endtask

    //------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------

    initial
    begin
        int errs;
        int frozen;
        int frozen_ticks;

        void'($urandom(seed));
        key   = '1;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = error_count;
        repeat (2) @(negedge clk);
        if (led !== '0)
            value_error("led", 0, int'(led));
        check_full_scan();
        finish_test("reset", errs);

        errs = error_count;
        press_key(board_pkg::key_run);
        check_led("led_run", board_pkg::led_run, 1'b1);
        wait_ticks(5);
        press_key(board_pkg::key_run);
        frozen       = exp_count;
        frozen_ticks = tick_count;
        repeat (3 * tick_period) @(posedge clk);
        if (exp_count != frozen || tick_count != frozen_ticks)
            check_failed("count moved after the second run press");
        if (exp_count < 5)
            value_error("count", 5, exp_count);
        finish_test("run_stop", errs);

        errs = error_count;
        press_key(board_pkg::key_clear);
        press_key(board_pkg::key_dir);
        press_key(board_pkg::key_run);
        wait_ticks(3);
        press_key(board_pkg::key_run);
        check_led("led_down", board_pkg::led_down, 1'b1);
        check_full_scan();
        finish_test("count_down", errs);

        errs = error_count;
        press_key(board_pkg::key_clear);
        check_led("led_ovf", board_pkg::led_ovf, 1'b0);
        press_key(board_pkg::key_dir);
        press_key(board_pkg::key_run);
        wait_count(count_mod - 1, count_mod + 10);
        check_led("led_ovf", board_pkg::led_ovf, 1'b0);
        wait_ticks(1);
        check_led("led_ovf", board_pkg::led_ovf, 1'b1);
        press_key(board_pkg::key_run);
        press_key(board_pkg::key_clear);
        check_led("led_ovf", board_pkg::led_ovf, 1'b0);
        check_full_scan();
        finish_test("overflow_clear", errs);

        errs = error_count;
        press_key(board_pkg::key_run);
        wait_ticks(3);
        press_key(board_pkg::key_run);
        @(negedge clk);
        frozen = exp_count;
        for (int k = 0; k < board_pkg::w_key; k++)
        begin
            short_pulse(k);
            short_pulse(k);
        end
        repeat (2 * tick_period) @(posedge clk);
        check_led("led_run", board_pkg::led_run, exp_run);
        check_led("led_down", board_pkg::led_down, exp_down);
        if (exp_count != frozen)
            value_error("count", frozen, exp_count);
        finish_test("short_pulses", errs);

        errs = error_count;
        check_full_scan();
        finish_test("scan", errs);

        $display("tests passed %0d failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(watchdog_ns);
        $display("run timed out after %0d ns, a test stopped making progress", watchdog_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* logic/board_specific_top.sv */
module board_specific_top
# (
    parameter   tick_period     = 2_700_000,  // 10 Hz count at 27 MHz
                debounce_cycles = 270_000,    // About 10 ms
                scan_period     = 27_000      // 1 ms per digit
)
(
    input                                  clk,
    input                                  rst_n,

    input  [board_pkg::w_key       - 1:0]  key,

    output [board_pkg::w_led       - 1:0]  led,

    output [                         7:0]  abcdefgh,
    output [display_pkg::n_digits  - 1:0]  digit
);

    //----------------------------------------------------------

    logic [board_pkg::w_key - 1:0]  key_pressed;
    logic                           tick;
    logic [display_pkg::n_digits:0] carry;  // Ripple chain between digits
    display_pkg::bcd_t              values [display_pkg::n_digits];

    count_ctrl_if ctrl_if ();

    assign key_pressed = ~ key;  // Keys pull low when pressed

    //----------------------------------------------------------

    tick_gen # (.tick_period (tick_period))
    i_tick_gen
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tick  ( tick  )
    );

    key_frontend # (.debounce_cycles (debounce_cycles))
    i_key_frontend
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .key_pressed ( key_pressed ),
        .tick        ( tick        ),
        .ctrl        ( ctrl_if     )
    );

    //----------------------------------------------------------
    // Counter digits, least significant first
    //----------------------------------------------------------

    assign carry [0] = ctrl_if.step;

    generate
        genvar i;

        for (i = 0; i < display_pkg::n_digits; i ++)
        begin : dig
            bcd_digit i_digit
            (
                .clk       ( clk          ),
                .rst_n     ( rst_n        ),
                .ctrl      ( ctrl_if      ),
                .carry_in  ( carry [i]     ),
                .carry_out ( carry [i + 1] ),
                .value     ( values [i]    )
            );
        end
    endgenerate

    //----------------------------------------------------------

    digit_scan # (.scan_period (scan_period))
    i_digit_scan
    (
        .clk      ( clk                            ),
        .rst_n    ( rst_n                          ),
        .ctrl     ( ctrl_if                        ),
        .values   ( values                         ),
        .overflow ( carry [display_pkg::n_digits]  ),
        .abcdefgh ( abcdefgh                       ),
        .digit    ( digit                          ),
        .led      ( led                            )
    );

endmodule

/* logic/digit_scan.sv */
module digit_scan
# (
    parameter scan_period = 27_000
)
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    count_ctrl_if.digit                           ctrl,
    input  display_pkg::bcd_t                     values [display_pkg::n_digits],
    input  logic                                  overflow,
    output logic [7:0]                            abcdefgh,
    output logic [display_pkg::n_digits - 1:0]    digit,
    output logic [board_pkg::w_led - 1:0]         led
);

    localparam w_cnt = scan_period > 1 ? $clog2(scan_period) : 1;
    localparam w_idx = display_pkg::n_digits > 1 ? $clog2(display_pkg::n_digits) : 1;

    logic [w_cnt - 1:0]                 scan_cnt;
    logic [w_idx - 1:0]                 scan_idx;   // Digit being shown
    logic [display_pkg::n_digits - 1:0] digit_next;
    display_pkg::seg_word_u             seg_next;

    logic tick_led_q;
    logic ovf_led_q;

    function automatic display_pkg::seg_word_u encode_bcd(input display_pkg::bcd_t bcd);
        display_pkg::seg_word_u w;
        w = display_pkg::seg_blank;
        w.seg.a = bcd inside {4'd0, 4'd2, 4'd3, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9};
        w.seg.b = bcd inside {4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd7, 4'd8, 4'd9};
        w.seg.c = bcd inside {4'd0, 4'd1, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9};
        w.seg.d = bcd inside {4'd0, 4'd2, 4'd3, 4'd5, 4'd6, 4'd8, 4'd9};
        w.seg.e = bcd inside {4'd0, 4'd2, 4'd6, 4'd8};
        w.seg.f = bcd inside {4'd0, 4'd4, 4'd5, 4'd6, 4'd8, 4'd9};
        w.seg.g = bcd inside {4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd8, 4'd9};
        return w;
    endfunction

    // Board pins are wired h first
    function automatic logic [7:0] to_board(input display_pkg::seg_word_u w);
        return {<<{w.raw}};
    endfunction

    //----------------------------------------------------------
    // Digit scan
    //----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scan_cnt <= '0;
            scan_idx <= '0;
        end
        else if (scan_cnt == w_cnt'(scan_period - 1))
        begin
            scan_cnt <= '0;
            if (scan_idx == w_idx'(display_pkg::n_digits - 1))
                scan_idx <= '0;
            else
                scan_idx <= scan_idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_comb
    begin
        digit_next           = '0;
        digit_next[scan_idx] = 1'b1;
        seg_next             = encode_bcd(values[scan_idx]);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            digit    <= {{(display_pkg::n_digits - 1){1'b0}}, 1'b1};  // Digit 0
            abcdefgh <= to_board(encode_bcd(4'd0));
        end
        else
        begin
            digit    <= digit_next;
            abcdefgh <= to_board(seg_next);
        end
    end

    //----------------------------------------------------------
    // Status LEDs
    //----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tick_led_q <= 1'b0;
            ovf_led_q  <= 1'b0;
        end
        else
        begin
            if (ctrl.tick & ctrl.running)
                tick_led_q <= ~tick_led_q;  // One toggle per counted tick

            if (ctrl.clear)
                ovf_led_q <= 1'b0;
            else if (overflow)
                ovf_led_q <= 1'b1;  // Held until the next clear
        end
    end

    assign led[board_pkg::led_run]  = ctrl.running;
    assign led[board_pkg::led_down] = ctrl.down;
    assign led[board_pkg::led_tick] = tick_led_q;
    assign led[board_pkg::led_ovf]  = ovf_led_q;

endmodule

/* logic/bcd_digit.sv */
module bcd_digit
(
    input  logic                clk,
    input  logic                rst_n,
    count_ctrl_if.digit         ctrl,
    input  logic                carry_in,
    output logic                carry_out,
    output display_pkg::bcd_t   value
);

    display_pkg::bcd_t value_q;
    logic              at_limit;  // Next step in this direction wraps

    assign at_limit = ctrl.down ? (value_q == 4'd0) : (value_q == 4'd9);

    // Ripples to the next digit in the same cycle.
    // A clear wins over the step, so no carry then.
    assign carry_out = carry_in & at_limit & ~ctrl.clear;

    //----------------------------------------------------------
    // Decimal up/down register
    //----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            value_q <= '0;
        else if (ctrl.clear)
            value_q <= '0;
        else if (carry_in)
        begin
            if (ctrl.down)
            begin
                if (value_q == 4'd0)
                    value_q <= 4'd9;  // Borrow
                else
                    value_q <= value_q - 4'd1;
            end
            else
            begin
                if (value_q == 4'd9)
                    value_q <= 4'd0;  // Carry
                else
                    value_q <= value_q + 4'd1;
            end
        end
    end

    assign value = value_q;

endmodule

/* logic/key_frontend.sv */
module key_frontend
# (
    parameter debounce_cycles = 270_000
)
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [board_pkg::w_key - 1:0] key_pressed,
    input  logic                         tick,
    count_ctrl_if.ctrl                   ctrl
);

    localparam w_cnt    = debounce_cycles > 1 ? $clog2(debounce_cycles) : 1;
    localparam sync_msb = board_pkg::sync_stages - 1;

    logic [board_pkg::sync_stages - 1:0] sync_q     [board_pkg::w_key];
    logic [w_cnt - 1:0]                  stable_cnt [board_pkg::w_key];

    logic [board_pkg::w_key - 1:0] deb_q;       // Debounced key levels
    logic [board_pkg::w_key - 1:0] deb_prev_q;  // Levels one cycle ago
    logic [board_pkg::w_key - 1:0] press;       // Press edges

    logic running_q;
    logic down_q;
    logic clear_q;

    //----------------------------------------------------------
    // Synchronize and debounce
    //----------------------------------------------------------

    // A new level is taken only after it differs from the
    // debounced one for debounce_cycles cycles in a row

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < board_pkg::w_key; i++)
            begin
                sync_q[i]     <= '0;
                stable_cnt[i] <= '0;
            end
            deb_q      <= '0;
            deb_prev_q <= '0;
        end
        else
        begin
            for (int i = 0; i < board_pkg::w_key; i++)
            begin
                sync_q[i] <= {sync_q[i][board_pkg::sync_stages - 2:0], key_pressed[i]};

                if (sync_q[i][sync_msb] == deb_q[i])
                    stable_cnt[i] <= '0;  // Bounce back, start over
                else if (stable_cnt[i] == w_cnt'(debounce_cycles - 1))
                begin
                    deb_q[i]      <= sync_q[i][sync_msb];
                    stable_cnt[i] <= '0;
                end
                else
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
            end

            deb_prev_q <= deb_q;
        end
    end

    assign press = deb_q & ~deb_prev_q;  // Release edges are ignored

    //----------------------------------------------------------
    // Run, direction and clear
    //----------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            running_q <= 1'b0;
            down_q    <= 1'b0;
            clear_q   <= 1'b0;
        end
        else
        begin
            running_q <= running_q ^ press[board_pkg::key_run];
            down_q    <= down_q    ^ press[board_pkg::key_dir];
            clear_q   <= press[board_pkg::key_clear];  // One cycle per press
        end
    end

    assign ctrl.step    = tick & running_q;
    assign ctrl.down    = down_q;
    assign ctrl.clear   = clear_q;
    assign ctrl.running = running_q;
    assign ctrl.tick    = tick;

endmodule

/* logic/tick_gen.sv */
module tick_gen
# (
    parameter tick_period = 2_700_000
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam w_cnt = tick_period > 1 ? $clog2(tick_period) : 1;

    logic [w_cnt - 1:0] cnt_q;  // Cycles left until the next strobe

    //----------------------------------------------------------
    // Reloading down-counter
    //----------------------------------------------------------

    // Strobe comes one cycle after the counter hits zero, which
    // puts the first one tick_period cycles after reset.

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt_q <= w_cnt'(tick_period - 1);
            tick  <= 1'b0;
        end
        else if (cnt_q == '0)
        begin
            cnt_q <= w_cnt'(tick_period - 1);  // Reload
            tick  <= 1'b1;
        end
        else
        begin
            cnt_q <= cnt_q - 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

/* logic/count_ctrl_if.sv */
interface count_ctrl_if;

    logic step;     // One-cycle count enable, tick gated by run
    logic down;     // Count direction, high means decrement
    logic clear;    // One-cycle pulse, zero all digits
    logic running;  // Run state level
    logic tick;     // Raw tick, ungated

    // Key front end drives the controls
    modport ctrl
    (
        output step,
        output down,
        output clear,
        output running,
        output tick
    );

    // Digits and the display driver only listen
    modport digit
    (
        input step,
        input down,
        input clear,
        input running,
        input tick
    );

endinterface

/* logic/display_pkg.sv */
package display_pkg;

    //----------------------------------------------------------
    // Counter digits
    //----------------------------------------------------------

    localparam n_digits = 4;  // Display shows 0000 to 9999

    typedef logic [3:0] bcd_t;  // One decimal digit, 0 to 9

    //----------------------------------------------------------
    // Seven-segment word
    //----------------------------------------------------------

    // Field a is the MSB of the raw vector, h (decimal point) the LSB.
    // The board expects the opposite order, so the driver reverses
    // the raw vector before it reaches the pins.

    typedef struct packed
    {
        logic a;  // Top
        logic b;  // Upper right
        logic c;  // Lower right
        logic d;  // Bottom
        logic e;  // Lower left
        logic f;  // Upper left
        logic g;  // Middle
        logic h;  // Decimal point
    } seg_fields_s;

    typedef union packed
    {
        seg_fields_s seg;  // Set by segment name when encoding
        logic [7:0]  raw;  // Same bits as a vector, a in bit 7
    } seg_word_u;

    localparam seg_word_u seg_blank = '0;  // All segments dark

    // Decimal to segment table, lit segments per digit:
    //   0 abcdef     5 acdfg
    //   1 bc         6 acdefg
    //   2 abdeg      7 abc
    //   3 abcdg      8 abcdefg
    //   4 bcfg       9 abcdfg
    // The decimal point h is never lit. Codes 10 to 15 are blank.

endpackage

/* logic/board_pkg.sv */
package board_pkg;

    //----------------------------------------------------------
    // Board I/O widths
    //----------------------------------------------------------

    localparam w_key = 3;  // Push buttons, active low on the pins
    localparam w_led = 4;  // Status LEDs, active high

    //----------------------------------------------------------
    // Key functions
    //----------------------------------------------------------

    // Each key acts on its press edge only

    localparam key_run   = 0;  // Start and stop the count
    localparam key_dir   = 1;  // Toggle up or down
    localparam key_clear = 2;  // Return all digits to zero

    //----------------------------------------------------------
    // LED functions
    //----------------------------------------------------------

    localparam led_run  = 0;  // Counter is running
    localparam led_down = 1;  // Counting down
    localparam led_tick = 2;  // Toggles on every counted tick
    localparam led_ovf  = 3;  // Sticky, last digit wrapped

    //----------------------------------------------------------
    // Input conditioning
    //----------------------------------------------------------

    // Flops between the pin and the debounce logic.
    // Keys are asynchronous to clk, so two is the minimum.

    localparam sync_stages = 2;

endpackage
